/* project.f */
hw/lc3b_types.sv
hw/lc3b_ctrl_pkg.sv
hw/control_rom.sv
hw/regfile.sv
hw/alu.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_stage.sv
hw/lc3b_pipe.sv
tb/lc3b_checker.sv
tb/tb_lc3b_pipe.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_lc3b_pipe

output="$(./obj_dir/Vtb_lc3b_pipe)"
echo "$output"

if grep -qF "Simulation finished: PASS" <<< "$output"; then
    exit 0
fi
exit 1

/* tb/tb_lc3b_pipe.sv */
module tb_lc3b_pipe;

    localparam int num_entries = 27;
    localparam int drain_limit = 50;

    localparam logic [1:0] ev_none = 2'd0;
    localparam logic [1:0] ev_wb = 2'd1;
    localparam logic [1:0] ev_store = 2'd2;
    localparam logic [1:0] ev_redirect = 2'd3;

    // spacing before an entry: random idle, two idle for a hazard, or none in a burst
    localparam logic [1:0] gap_random = 2'd0;
    localparam logic [1:0] gap_dep = 2'd1;
    localparam logic [1:0] gap_burst = 2'd2;

    typedef struct packed {
        logic [15:0] instr;
        logic [15:0] pc;
        logic [1:0] kind;
        logic [15:0] where;
        logic [15:0] value;
        logic [1:0] be;
        logic [1:0] gap;
    } entry_t;

    logic clk;
    logic rst_n;
    logic instr_valid;
    logic [15:0] instr;
    logic [15:0] instr_pc;
    logic wb_valid;
    logic [2:0] wb_reg;
    logic [15:0] wb_data;
    logic [2:0] cc;
    logic mem_wr_valid;
    logic [15:0] mem_wr_addr;
    logic [15:0] mem_wr_data;
    logic [1:0] mem_wr_be;
    logic pc_load;
    logic [15:0] pc_target;

    logic exp_valid;
    logic [1:0] exp_kind;
    logic [15:0] exp_where;
    logic [15:0] exp_value;
    logic [1:0] exp_be;
    int mismatch_count;
    int unexpected_count;
    int pending_count;

    entry_t program_table [num_entries];
    int idle_cycles;
    int drain_cycles;

    always #50 clk = ~clk;

    lc3b_pipe #(
        .MEM_WORDS (256)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_pc     (instr_pc),
        .wb_valid     (wb_valid),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .cc           (cc),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_data  (mem_wr_data),
        .mem_wr_be    (mem_wr_be),
        .pc_load      (pc_load),
        .pc_target    (pc_target)
    );

    lc3b_checker u_checker (
        .clk              (clk),
        .rst_n            (rst_n),
        .exp_valid        (exp_valid),
        .exp_kind         (exp_kind),
        .exp_where        (exp_where),
        .exp_value        (exp_value),
        .exp_be           (exp_be),
        .wb_valid         (wb_valid),
        .wb_reg           (wb_reg),
        .wb_data          (wb_data),
        .cc               (cc),
        .mem_wr_valid     (mem_wr_valid),
        .mem_wr_addr      (mem_wr_addr),
        .mem_wr_data      (mem_wr_data),
        .mem_wr_be        (mem_wr_be),
        .pc_load          (pc_load),
        .pc_target        (pc_target),
        .mismatch_count   (mismatch_count),
        .unexpected_count (unexpected_count),
        .pending_count    (pending_count)
    );

    // registers start at zero, so every expected value follows from the table alone
    task automatic load_table();
        // ALU forms: r1=5, r2=-3, r3=0, r4=2, r5=5, r6=fffc, r7=fffa
        program_table[0] = '{16'h1225, 16'h3000, ev_wb, 16'h0001, 16'h0005, 2'b00, gap_random};
        program_table[1] = '{16'h143d, 16'h3002, ev_wb, 16'h0002, 16'hfffd, 2'b00, gap_random};
        program_table[2] = '{16'h5660, 16'h3004, ev_wb, 16'h0003, 16'h0000, 2'b00, gap_dep};
        program_table[3] = '{16'h1842, 16'h3006, ev_wb, 16'h0004, 16'h0002, 2'b00, gap_random};
        program_table[4] = '{16'h5a81, 16'h3008, ev_wb, 16'h0005, 16'h0005, 2'b00, gap_random};
        program_table[5] = '{16'h5cbc, 16'h300a, ev_wb, 16'h0006, 16'hfffc, 2'b00, gap_random};
        program_table[6] = '{16'h9e7f, 16'h300c, ev_wb, 16'h0007, 16'hfffa, 2'b00, gap_random};
        // STR r7 to r4+6, then LDR it back
        program_table[7] = '{16'h7f03, 16'h300e, ev_store, 16'h0008, 16'hfffa, 2'b11, gap_dep};
        program_table[8] = '{16'h6703, 16'h3010, ev_wb, 16'h0003, 16'hfffa, 2'b00, gap_random};
        // STB to byte 3 and byte 2, then LDB both bytes
        program_table[9] = '{16'h3301, 16'h3012, ev_store, 16'h0002, 16'h0505, 2'b10, gap_random};
        program_table[10] = '{16'h3f00, 16'h3014, ev_store, 16'h0002, 16'hfafa, 2'b01, gap_random};
        program_table[11] = '{16'h2b01, 16'h3016, ev_wb, 16'h0005, 16'h0005, 2'b00, gap_random};
        program_table[12] = '{16'h2d00, 16'h3018, ev_wb, 16'h0006, 16'h00fa, 2'b00, gap_random};
        // BRp taken, BRn not taken, BR with nzp of zero
        program_table[13] = '{16'h0204, 16'h301a, ev_redirect, 16'h0000, 16'h3024, 2'b00, gap_dep};
        program_table[14] = '{16'h09fe, 16'h301c, ev_none, 16'h0000, 16'h0000, 2'b00, gap_random};
        program_table[15] = '{16'h0005, 16'h301e, ev_none, 16'h0000, 16'h0000, 2'b00, gap_random};
        program_table[16] = '{16'h1620, 16'h3020, ev_wb, 16'h0003, 16'h0000, 2'b00, gap_random};
        program_table[17] = '{16'h05f8, 16'h3022, ev_redirect, 16'h0000, 16'h3014, 2'b00, gap_dep};
        // JMP through r6 and r7
        program_table[18] = '{16'hc180, 16'h3024, ev_redirect, 16'h0000, 16'h00fa, 2'b00, gap_random};
        program_table[19] = '{16'hc1c0, 16'h3026, ev_redirect, 16'h0000, 16'hfffa, 2'b00, gap_random};
        // independent burst with two unsupported opcodes mixed in
        program_table[20] = '{16'h1221, 16'h3028, ev_wb, 16'h0001, 16'h0001, 2'b00, gap_random};
        program_table[21] = '{16'hd123, 16'h302a, ev_none, 16'h0000, 16'h0000, 2'b00, gap_burst};
        program_table[22] = '{16'h143f, 16'h302c, ev_wb, 16'h0002, 16'hffff, 2'b00, gap_burst};
        program_table[23] = '{16'h5b04, 16'h302e, ev_wb, 16'h0005, 16'h0002, 2'b00, gap_burst};
        program_table[24] = '{16'h9e3f, 16'h3030, ev_wb, 16'h0007, 16'hffff, 2'b00, gap_burst};
        program_table[25] = '{16'hf025, 16'h3032, ev_none, 16'h0000, 16'h0000, 2'b00, gap_burst};
        program_table[26] = '{16'h1c2f, 16'h3034, ev_wb, 16'h0006, 16'h000f, 2'b00, gap_burst};
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr = 16'h0000;
        exp_valid = 1'b0;
    endtask

    task automatic issue_entry(input entry_t e);
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instr = e.instr;
        instr_pc = e.pc;
        exp_valid = 1'b1;
        exp_kind = e.kind;
        exp_where = e.where;
        exp_value = e.value;
        exp_be = e.be;
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = 16'h0000;
        instr_pc = 16'h0000;
        exp_valid = 1'b0;
        exp_kind = ev_none;
        exp_where = 16'h0000;
        exp_value = 16'h0000;
        exp_be = 2'b00;
        void'($urandom(85140));
        load_table();

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < num_entries; i++) begin
            idle_cycles = 0;
            if (program_table[i].gap == gap_dep) begin
                idle_cycles = 2;
            end
            if (program_table[i].gap != gap_burst) begin
                idle_cycles += int'($urandom % 3);
            end
            repeat (idle_cycles) drive_idle();
            issue_entry(program_table[i]);
        end
        drive_idle();

        // wait until every expected event has come out of the pipe
        drain_cycles = 0;
        do begin
            @(posedge clk);
            drain_cycles++;
        end while (pending_count != 0 && drain_cycles < drain_limit);

        // a short quiet window catches stray events after the last one
        repeat (4) @(posedge clk);

        if (pending_count != 0) begin
            $display("timeout: %0d expected events did not appear within %0d cycles",
                     pending_count, drain_limit);
        end
        $display("errors: %0d mismatched, %0d unexpected, %0d missing",
                 mismatch_count, unexpected_count, pending_count);
        if (mismatch_count + unexpected_count + pending_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : tb_lc3b_pipe

/* tb/lc3b_checker.sv */
module lc3b_checker (
    input  logic clk,
    input  logic rst_n,
    input  logic exp_valid,
    input  logic [1:0] exp_kind,
    input  logic [15:0] exp_where,
    input  logic [15:0] exp_value,
    input  logic [1:0] exp_be,
    input  logic wb_valid,
    input  logic [2:0] wb_reg,
    input  logic [15:0] wb_data,
    input  logic [2:0] cc,
    input  logic mem_wr_valid,
    input  logic [15:0] mem_wr_addr,
    input  logic [15:0] mem_wr_data,
    input  logic [1:0] mem_wr_be,
    input  logic pc_load,
    input  logic [15:0] pc_target,
    output int mismatch_count,
    output int unexpected_count,
    output int pending_count
);
    localparam logic [1:0] ev_wb = 2'd1;
    localparam logic [1:0] ev_store = 2'd2;
    localparam logic [1:0] ev_redirect = 2'd3;

    // one FIFO per event kind since each kind leaves the pipe in issue order
    logic [15:0] wb_reg_q [$];
    logic [15:0] wb_data_q [$];
    logic [15:0] st_addr_q [$];
    logic [15:0] st_data_q [$];
    logic [1:0] st_be_q [$];
    logic [15:0] target_q [$];

    int mismatches = 0;
    int unexpected = 0;
    int pending = 0;

    assign mismatch_count = mismatches;
    assign unexpected_count = unexpected;
    assign pending_count = pending;

    task automatic check_value(input string name, input logic [15:0] want,
                               input logic [15:0] got);
        if (got !== want) begin
            $display("error: %s expected 0x%h got 0x%h at time %0t", name, want, got, $time);
            mismatches++;
        end
    endtask

    // n, z and p as the ISA defines them for a 16-bit result
    function automatic logic [2:0] flags_of(input logic [15:0] value);
        if (value == 16'h0000) begin
            return 3'b010;
        end else if (value[15]) begin
            return 3'b100;
        end
        return 3'b001;
    endfunction

    task automatic record_expectation();
        case (exp_kind)
            ev_wb: begin
                wb_reg_q.push_back(exp_where);
                wb_data_q.push_back(exp_value);
            end
            ev_store: begin
                st_addr_q.push_back(exp_where);
                st_data_q.push_back(exp_value);
                st_be_q.push_back(exp_be);
            end
            ev_redirect: begin
                target_q.push_back(exp_value);
            end
            default: begin
            end
        endcase
    endtask

    task automatic check_writeback();
        logic [15:0] want_data;

        if (wb_data_q.size() == 0) begin
            $display("writeback to r%0d arrived with no instruction expecting it", wb_reg);
            unexpected++;
        end else begin
            want_data = wb_data_q.pop_front();
            check_value("wb_reg", wb_reg_q.pop_front(), {13'h0000, wb_reg});
            check_value("wb_data", want_data, wb_data);
            // the newest writer is the one in the last stage so cc follows its data
            check_value("cc", {13'h0000, flags_of(want_data)}, {13'h0000, cc});
        end
    endtask

    task automatic check_store();
        if (st_data_q.size() == 0) begin
            $display("memory write to 0x%h arrived with no store expecting it", mem_wr_addr);
            unexpected++;
        end else begin
            check_value("mem_wr_addr", st_addr_q.pop_front(), mem_wr_addr);
            check_value("mem_wr_data", st_data_q.pop_front(), mem_wr_data);
            check_value("mem_wr_be", {14'h0000, st_be_q.pop_front()}, {14'h0000, mem_wr_be});
        end
    endtask

    task automatic check_redirect();
        if (target_q.size() == 0) begin
            $display("redirect to 0x%h arrived with no branch or jump expecting it", pc_target);
            unexpected++;
        end else begin
            check_value("pc_target", target_q.pop_front(), pc_target);
        end
    endtask

    task automatic check_reset_state();
        check_value("wb_valid", 16'h0000, {15'h0000, wb_valid});
        check_value("mem_wr_valid", 16'h0000, {15'h0000, mem_wr_valid});
        check_value("pc_load", 16'h0000, {15'h0000, pc_load});
        check_value("cc", 16'h0002, {13'h0000, cc});
    endtask

    // registered outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            check_reset_state();
        end else begin
            if (exp_valid) begin
                record_expectation();
            end
            if (wb_valid) begin
                check_writeback();
            end
            if (mem_wr_valid) begin
                check_store();
            end
            if (pc_load) begin
                check_redirect();
            end
        end
        pending = wb_data_q.size() + st_data_q.size() + target_q.size();
    end

endmodule : lc3b_checker

/* hw/lc3b_pipe.sv */
module lc3b_pipe #(
    parameter int MEM_WORDS = 256
) (
    input  logic clk,
    input  logic rst_n,
    input  logic instr_valid,
    input  lc3b_types::lc3b_word instr,
    input  lc3b_types::lc3b_word instr_pc,
    output logic wb_valid,
    output lc3b_types::lc3b_reg wb_reg,
    output lc3b_types::lc3b_word wb_data,
    output logic [2:0] cc,
    output logic mem_wr_valid,
    output lc3b_types::lc3b_word mem_wr_addr,
    output lc3b_types::lc3b_word mem_wr_data,
    output logic [1:0] mem_wr_be,
    output logic pc_load,
    output lc3b_types::lc3b_word pc_target
);
    import lc3b_types::*;
    import lc3b_ctrl_pkg::*;

    lc3b_reg src_a;
    lc3b_reg src_b;
    lc3b_word reg_a;
    lc3b_word reg_b;
    logic rf_load;
    lc3b_reg rf_dest;
    lc3b_word rf_data;

    logic d_valid;
    lc3b_control_word d_ctrl;
    lc3b_word d_a;
    lc3b_word d_b;
    lc3b_word d_imm5;
    lc3b_word d_off6;
    lc3b_word d_off9;
    logic [2:0] d_nzp;
    lc3b_reg d_dest;
    lc3b_word d_pc;

    logic e_valid;
    logic e_load_regfile;
    logic e_load_cc;
    logic e_mem_read;
    logic e_mem_write;
    logic [1:0] e_byte_enable;
    logic e_filter;
    logic [1:0] e_regfilemux_sel;
    lc3b_word e_result;
    lc3b_word e_store;
    lc3b_reg e_dest;

    decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .reg_a       (reg_a),
        .reg_b       (reg_b),
        .src_a       (src_a),
        .src_b       (src_b),
        .d_valid     (d_valid),
        .d_ctrl      (d_ctrl),
        .d_a         (d_a),
        .d_b         (d_b),
        .d_imm5      (d_imm5),
        .d_off6      (d_off6),
        .d_off9      (d_off9),
        .d_nzp       (d_nzp),
        .d_dest      (d_dest),
        .d_pc        (d_pc)
    );

    regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (rf_load),
        .dest  (rf_dest),
        .in    (rf_data),
        .src_a (src_a),
        .src_b (src_b),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    execute_stage u_execute (
        .clk              (clk),
        .rst_n            (rst_n),
        .d_valid          (d_valid),
        .d_ctrl           (d_ctrl),
        .d_a              (d_a),
        .d_b              (d_b),
        .d_imm5           (d_imm5),
        .d_off6           (d_off6),
        .d_off9           (d_off9),
        .d_nzp            (d_nzp),
        .d_dest           (d_dest),
        .d_pc             (d_pc),
        .cc               (cc),
        .pc_load          (pc_load),
        .pc_target        (pc_target),
        .e_valid          (e_valid),
        .e_load_regfile   (e_load_regfile),
        .e_load_cc        (e_load_cc),
        .e_mem_read       (e_mem_read),
        .e_mem_write      (e_mem_write),
        .e_byte_enable    (e_byte_enable),
        .e_filter         (e_filter),
        .e_regfilemux_sel (e_regfilemux_sel),
        .e_result         (e_result),
        .e_store          (e_store),
        .e_dest           (e_dest)
    );

    mem_stage #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .clk              (clk),
        .rst_n            (rst_n),
        .e_valid          (e_valid),
        .e_load_regfile   (e_load_regfile),
        .e_load_cc        (e_load_cc),
        .e_mem_read       (e_mem_read),
        .e_mem_write      (e_mem_write),
        .e_byte_enable    (e_byte_enable),
        .e_filter         (e_filter),
        .e_regfilemux_sel (e_regfilemux_sel),
        .e_result         (e_result),
        .e_store          (e_store),
        .e_dest           (e_dest),
        .rf_load          (rf_load),
        .rf_dest          (rf_dest),
        .rf_data          (rf_data),
        .wb_valid         (wb_valid),
        .wb_reg           (wb_reg),
        .wb_data          (wb_data),
        .cc               (cc),
        .mem_wr_valid     (mem_wr_valid),
        .mem_wr_addr      (mem_wr_addr),
        .mem_wr_data      (mem_wr_data),
        .mem_wr_be        (mem_wr_be)
    );

endmodule : lc3b_pipe

/* hw/mem_stage.sv */
module mem_stage #(
    parameter int MEM_WORDS = 256
) (
    input  logic clk,
    input  logic rst_n,
    input  logic e_valid,
    input  logic e_load_regfile,
    input  logic e_load_cc,
    input  logic e_mem_read,
    input  logic e_mem_write,
    input  logic [1:0] e_byte_enable,
    input  logic e_filter,
    input  logic [1:0] e_regfilemux_sel,
    input  lc3b_types::lc3b_word e_result,
    input  lc3b_types::lc3b_word e_store,
    input  lc3b_types::lc3b_reg e_dest,
    output logic rf_load,
    output lc3b_types::lc3b_reg rf_dest,
    output lc3b_types::lc3b_word rf_data,
    output logic wb_valid,
    output lc3b_types::lc3b_reg wb_reg,
    output lc3b_types::lc3b_word wb_data,
    output logic [2:0] cc,
    output logic mem_wr_valid,
    output lc3b_types::lc3b_word mem_wr_addr,
    output lc3b_types::lc3b_word mem_wr_data,
    output logic [1:0] mem_wr_be
);
    import lc3b_types::*;
    import lc3b_ctrl_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    lc3b_word mem [MEM_WORDS];
    logic [AW-1:0] word_idx;
    logic mem_we;
    lc3b_word rdata;
    lc3b_word load_data;
    logic [2:0] next_cc;

    // byte address bits above the array size are dropped so addresses wrap
    assign word_idx = e_result[AW:1];
    assign mem_we = e_valid && e_mem_write;

    always_ff @(posedge clk) begin
        if (mem_we && e_byte_enable[0]) begin
            mem[word_idx][7:0] <= e_store[7:0];
        end
        if (mem_we && e_byte_enable[1]) begin
            mem[word_idx][15:8] <= e_store[15:8];
        end
    end

    assign rdata = (e_valid && e_mem_read) ? mem[word_idx] : '0;
    assign load_data = e_filter ? {8'h00, (e_result[0] ? rdata[15:8] : rdata[7:0])} : rdata;

    assign rf_load = e_valid && e_load_regfile;
    assign rf_dest = e_dest;
    assign rf_data = (e_regfilemux_sel == regfilemux_mem) ? load_data : e_result;

    assign next_cc = {rf_data[15], rf_data == 16'h0000, !rf_data[15] && rf_data != 16'h0000};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            mem_wr_valid <= 1'b0;
            cc <= 3'b010;
        end else begin
            wb_valid <= rf_load;
            mem_wr_valid <= mem_we;
            if (e_valid && e_load_cc) begin
                cc <= next_cc;
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_reg <= e_dest;
        wb_data <= rf_data;
        mem_wr_addr <= {e_result[15:1], 1'b0};
        mem_wr_data <= e_store;
        mem_wr_be <= e_byte_enable;
    end

    // the control table never gives one instruction both a writeback and a store
    a_wb_or_store: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb_valid && mem_wr_valid));

endmodule : mem_stage

/* hw/execute_stage.sv */
module execute_stage (
    input  logic clk,
    input  logic rst_n,
    input  logic d_valid,
    input  lc3b_ctrl_pkg::lc3b_control_word d_ctrl,
    input  lc3b_types::lc3b_word d_a,
    input  lc3b_types::lc3b_word d_b,
    input  lc3b_types::lc3b_word d_imm5,
    input  lc3b_types::lc3b_word d_off6,
    input  lc3b_types::lc3b_word d_off9,
    input  logic [2:0] d_nzp,
    input  lc3b_types::lc3b_reg d_dest,
    input  lc3b_types::lc3b_word d_pc,
    input  logic [2:0] cc,
    output logic pc_load,
    output lc3b_types::lc3b_word pc_target,
    output logic e_valid,
    output logic e_load_regfile,
    output logic e_load_cc,
    output logic e_mem_read,
    output logic e_mem_write,
    output logic [1:0] e_byte_enable,
    output logic e_filter,
    output logic [1:0] e_regfilemux_sel,
    output lc3b_types::lc3b_word e_result,
    output lc3b_types::lc3b_word e_store,
    output lc3b_types::lc3b_reg e_dest
);
    import lc3b_types::*;
    import lc3b_ctrl_pkg::*;

    lc3b_word off6_scaled;
    lc3b_word alu_b;
    lc3b_word alu_f;
    lc3b_word br_target;
    logic redirect;

    assign off6_scaled = d_ctrl.offset6mux_sel ? {d_off6[14:0], 1'b0} : d_off6;

    always_comb begin
        case (d_ctrl.alumux_sel)
            alumux_offset6: alu_b = off6_scaled;
            alumux_imm5: alu_b = d_imm5;
            default: alu_b = d_b;
        endcase
    end

    alu u_alu (
        .aluop (d_ctrl.aluop),
        .a     (d_a),
        .b     (alu_b),
        .f     (alu_f)
    );

    // conditional branches test the cc as it stands after older writebacks
    assign redirect = d_valid && d_ctrl.load_pc &&
        (!d_ctrl.brmux_sel || ((d_nzp & cc) != 3'b000));
    assign br_target = d_pc + 16'd2 + {d_off9[14:0], 1'b0};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_valid <= 1'b0;
            e_load_regfile <= 1'b0;
            e_load_cc <= 1'b0;
            e_mem_read <= 1'b0;
            e_mem_write <= 1'b0;
            pc_load <= 1'b0;
        end else begin
            e_valid <= d_valid;
            e_load_regfile <= d_ctrl.load_regfile;
            e_load_cc <= d_ctrl.load_cc;
            e_mem_read <= d_ctrl.mem_read;
            e_mem_write <= d_ctrl.mem_write;
            pc_load <= redirect;
        end
    end

    always_ff @(posedge clk) begin
        e_byte_enable <= d_ctrl.mem_byte_enable;
        e_filter <= d_ctrl.regfile_filter_enable;
        e_regfilemux_sel <= d_ctrl.regfilemux_sel;
        e_result <= alu_f;
        e_store <= d_ctrl.stb_filter_enable ? {d_b[7:0], d_b[7:0]} : d_b;
        e_dest <= d_dest;
        pc_target <= (d_ctrl.pcmux_sel == pcmux_reg) ? d_a : br_target;
    end

endmodule : execute_stage

/* hw/decode_stage.sv */
module decode_stage (
    input  logic clk,
    input  logic rst_n,
    input  logic instr_valid,
    input  lc3b_types::lc3b_word instr,
    input  lc3b_types::lc3b_word instr_pc,
    input  lc3b_types::lc3b_word reg_a,
    input  lc3b_types::lc3b_word reg_b,
    output lc3b_types::lc3b_reg src_a,
    output lc3b_types::lc3b_reg src_b,
    output logic d_valid,
    output lc3b_ctrl_pkg::lc3b_control_word d_ctrl,
    output lc3b_types::lc3b_word d_a,
    output lc3b_types::lc3b_word d_b,
    output lc3b_types::lc3b_word d_imm5,
    output lc3b_types::lc3b_word d_off6,
    output lc3b_types::lc3b_word d_off9,
    output logic [2:0] d_nzp,
    output lc3b_types::lc3b_reg d_dest,
    output lc3b_types::lc3b_word d_pc
);
    import lc3b_types::*;
    import lc3b_ctrl_pkg::*;

    lc3b_opcode opcode;
    lc3b_control_word ctrl;
    logic is_nop;
    logic stb_high_enable;

    assign opcode = lc3b_opcode'(instr[15:12]);

    // stores carry their source register in the destination field
    assign src_a = instr[8:6];
    assign src_b = (opcode == op_str || opcode == op_stb) ? instr[11:9] : instr[2:0];

    assign is_nop = (opcode == op_br) && (instr[11:9] == 3'b000);

    // the low address bit is exact without the full add since nothing carries into it
    assign stb_high_enable = reg_a[0] ^ instr[0];

    control_rom u_control_rom (
        .opcode          (opcode),
        .imm_enable      (instr[5]),
        .stb_high_enable (stb_high_enable),
        .is_nop          (is_nop),
        .ctrl            (ctrl)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
            d_ctrl <= '0;
        end else begin
            d_valid <= instr_valid;
            d_ctrl <= ctrl;
        end
    end

    always_ff @(posedge clk) begin
        d_a <= reg_a;
        d_b <= reg_b;
        d_imm5 <= {{11{instr[4]}}, instr[4:0]};
        d_off6 <= {{10{instr[5]}}, instr[5:0]};
        d_off9 <= {{7{instr[8]}}, instr[8:0]};
        d_nzp <= instr[11:9];
        d_dest <= instr[11:9];
        d_pc <= instr_pc;
    end

endmodule : decode_stage

/* hw/alu.sv */
module alu (
    input  lc3b_types::lc3b_aluop aluop,
    input  lc3b_types::lc3b_word a,
    input  lc3b_types::lc3b_word b,
    output lc3b_types::lc3b_word f
);
    import lc3b_types::*;

    always_comb begin
        case (aluop)
            alu_add: f = a + b;
            alu_and: f = a & b;
            alu_not: f = ~a;
            default: f = b;
        endcase
    end

endmodule : alu

/* hw/regfile.sv */
module regfile (
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    input  lc3b_types::lc3b_reg dest,
    input  lc3b_types::lc3b_word in,
    input  lc3b_types::lc3b_reg src_a,
    input  lc3b_types::lc3b_reg src_b,
    output lc3b_types::lc3b_word reg_a,
    output lc3b_types::lc3b_word reg_b
);
    import lc3b_types::*;

    lc3b_word data [8];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                data[i] <= '0;
            end
        end else if (load) begin
            data[dest] <= in;
        end
    end

    // reads see the old value during a same-cycle write
    assign reg_a = data[src_a];
    assign reg_b = data[src_b];

    a_dest_known: assert property (@(posedge clk) disable iff (!rst_n)
        load |-> !$isunknown(dest));

endmodule : regfile

/* hw/control_rom.sv */
module control_rom (
    input  lc3b_types::lc3b_opcode opcode,
    input  logic imm_enable,
    input  logic stb_high_enable,
    input  logic is_nop,
    output lc3b_ctrl_pkg::lc3b_control_word ctrl
);
    import lc3b_types::*;
    import lc3b_ctrl_pkg::*;

    always_comb begin
        ctrl = '0;
        ctrl.aluop = alu_add;
        ctrl.mem_byte_enable = 2'b11;

        case (opcode)
            op_add: begin
                ctrl.aluop = alu_add;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                if (imm_enable) begin
                    ctrl.alumux_sel = alumux_imm5;
                end
            end
            op_and: begin
                ctrl.aluop = alu_and;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                if (imm_enable) begin
                    ctrl.alumux_sel = alumux_imm5;
                end
            end
            op_not: begin
                ctrl.aluop = alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            op_ldr: begin
                // word offsets are scaled by two before the address add
                ctrl.alumux_sel = alumux_offset6;
                ctrl.offset6mux_sel = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.regfilemux_sel = regfilemux_mem;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            op_ldb: begin
                ctrl.alumux_sel = alumux_offset6;
                ctrl.mem_read = 1'b1;
                ctrl.regfilemux_sel = regfilemux_mem;
                ctrl.regfile_filter_enable = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            op_str: begin
                ctrl.alumux_sel = alumux_offset6;
                ctrl.offset6mux_sel = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            op_stb: begin
                // the byte lane follows the low bit of the effective address
                ctrl.alumux_sel = alumux_offset6;
                ctrl.stb_filter_enable = 1'b1;
                ctrl.mem_byte_enable = stb_high_enable ? 2'b10 : 2'b01;
                ctrl.mem_write = 1'b1;
            end
            op_br: begin
                if (!is_nop) begin
                    ctrl.pcmux_sel = pcmux_branch;
                    ctrl.brmux_sel = 1'b1;
                    ctrl.load_pc = 1'b1;
                end
            end
            op_jmp: begin
                ctrl.pcmux_sel = pcmux_reg;
                ctrl.load_pc = 1'b1;
            end
            default: begin
                // unsupported opcodes travel down the pipe as bubbles
                ctrl = '0;
            end
        endcase
    end

endmodule : control_rom

/* hw/lc3b_ctrl_pkg.sv */
package lc3b_ctrl_pkg;

    typedef struct packed {
        lc3b_types::lc3b_opcode opcode;
        logic load_pc;
        logic load_ir;
        logic load_regfile;
        logic load_mar;
        logic load_mdr;
        logic load_cc;
        logic regfile_filter_enable;
        logic stb_filter_enable;
        logic [1:0] pcmux_sel;
        logic brmux_sel;
        logic storemux_sel;
        logic destmux_sel;
        logic [1:0] alumux_sel;
        logic [1:0] regfilemux_sel;
        logic [1:0] marmux_sel;
        logic mdrmux_sel;
        logic offsetaddermux_sel;
        logic offset6mux_sel;
        lc3b_types::lc3b_aluop aluop;
        logic mem_read;
        logic mem_write;
        logic [1:0] mem_byte_enable;
    } lc3b_control_word;

    // second ALU operand
    localparam logic [1:0] alumux_reg = 2'b00;
    localparam logic [1:0] alumux_offset6 = 2'b01;
    localparam logic [1:0] alumux_imm5 = 2'b10;

    // writeback source
    localparam logic [1:0] regfilemux_alu = 2'b00;
    localparam logic [1:0] regfilemux_mem = 2'b01;

    // redirect target
    localparam logic [1:0] pcmux_branch = 2'b00;
    localparam logic [1:0] pcmux_reg = 2'b11;

endpackage : lc3b_ctrl_pkg

/* hw/lc3b_types.sv */
package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;

    // full LC-3b opcode map, only part of it is executed by this core
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

endpackage : lc3b_types
